//--- ddr3_tele_pkg.sv
`default_nettype none

package ddr3_tele_pkg;

  // Record layout
  localparam int SNAP_WIDTH = 20;
  localparam int SEQ_WIDTH = 12;
  localparam int REC_WIDTH = SEQ_WIDTH + SNAP_WIDTH;

  // Record storage, level counts 0 to TELE_DEPTH inclusive
  localparam int TELE_DEPTH = 16;
  localparam int LEVEL_WIDTH = 5;

  // UART bit time in clock cycles
  localparam int CLKS_PER_BIT = 16;

  // Byte codes used by the dump
  localparam logic [7:0] ASCII_LF = 8'h0A;
  localparam logic [7:0] DUMP_CMD = 8'h61;  // "a"

  // Controller state as seen at the top level
  typedef struct packed {
    logic [4:0] fsm_state;
    logic [4:0] fsm_snext;
    logic [2:0] ddl_state;
    logic       cfg_rst_n;
    logic       cfg_run;
    logic       cfg_req;
    logic       cfg_ref;
    logic [2:0] cfg_cmd;
  } tele_snap_t;

  // One stored record, written as fields and read back as hex digits
  typedef union packed {
    struct packed {
      logic [SEQ_WIDTH-1:0] seq;
      tele_snap_t           snap;
    } fields;
    logic [7:0][3:0] nibbles;
  } tele_rec_t;

  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } uart_byte_t;

endpackage

`default_nettype wire

//--- tele_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module tele_fifo (
  input  wire                                    clock,
  input  wire                                    arst_n,
  input  wire                                    wr_en_i,
  input  ddr3_tele_pkg::tele_rec_t               wr_rec_i,
  input  wire                                    rd_en_i,
  output ddr3_tele_pkg::tele_rec_t               rd_rec_o,
  output logic                                   empty_o,
  output logic                                   full_o,
  output logic [ddr3_tele_pkg::LEVEL_WIDTH-1:0]  level_o
);
  import ddr3_tele_pkg::*;

  tele_rec_t mem_q [TELE_DEPTH];

  // Pointers are one bit narrower than the level, depth is a power of two
  logic [LEVEL_WIDTH-2:0] wr_ptr_q;
  logic [LEVEL_WIDTH-2:0] rd_ptr_q;
  logic [LEVEL_WIDTH-1:0] level_q;
  logic                   do_wr;
  logic                   do_rd;

  assign do_wr = wr_en_i && !full_o;
  assign do_rd = rd_en_i && !empty_o;

  always_ff @(posedge clock) begin
    if (do_wr) begin
      mem_q[wr_ptr_q] <= wr_rec_i;
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_rd) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   level_q <= level_q + 1'b1;
        2'b01:   level_q <= level_q - 1'b1;
        default: level_q <= level_q;
      endcase
    end
  end

  // Head record is visible without a read delay
  assign rd_rec_o = mem_q[rd_ptr_q];
  assign empty_o  = (level_q == '0);
  assign full_o   = (level_q == LEVEL_WIDTH'(TELE_DEPTH));
  assign level_o  = level_q;

endmodule

`default_nettype wire

//--- tele_capture.sv
`timescale 1ns/1ps
`default_nettype none

module tele_capture (
  input  wire                        clock,
  input  wire                        arst_n,
  input  ddr3_tele_pkg::tele_snap_t  snap_i,
  input  wire                        dumping_i,
  input  wire                        full_i,
  output logic                       wr_en_o,
  output ddr3_tele_pkg::tele_rec_t   wr_rec_o
);
  import ddr3_tele_pkg::*;

  tele_snap_t           prev_q;
  logic [SEQ_WIDTH-1:0] seq_q;
  logic                 changed;

  assign changed = (snap_i != prev_q);

  // Store only on a change, with room left and no dump running
  assign wr_en_o = changed && !dumping_i && !full_i;

  always_comb begin
    wr_rec_o.fields.seq  = seq_q;
    wr_rec_o.fields.snap = snap_i;
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      prev_q <= '0;
      seq_q  <= '0;
    end else begin
      // Keeps tracking the input during a dump as well
      prev_q <= snap_i;
      if (wr_en_o) begin
        seq_q <= seq_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- tele_dump.sv
`timescale 1ns/1ps
`default_nettype none

module tele_dump (
  input  wire                        clock,
  input  wire                        arst_n,
  input  wire                        send_ni,
  input  ddr3_tele_pkg::uart_byte_t  rx_byte_i,
  input  ddr3_tele_pkg::tele_rec_t   rd_rec_i,
  input  wire                        empty_i,
  input  wire                        tx_ready_i,
  output logic                       rd_en_o,
  output logic                       tx_valid_o,
  output logic [7:0]                 tx_data_o,
  output logic                       dumping_o
);
  import ddr3_tele_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CHECK,
    ST_HEX,
    ST_LF
  } dump_state_e;

  dump_state_e state_q;
  logic [2:0]  nib_q;
  logic        send_meta_q;
  logic        send_sync_q;
  logic        send_prev_q;
  logic        trigger;
  logic        tx_fire;

  // Upper-case hex digit
  function automatic logic [7:0] hex_ascii(input logic [3:0] nib);
    logic [7:0] ch;
    if (nib < 4'd10) begin
      ch = 8'h30 + {4'h0, nib};
    end else begin
      ch = 8'h37 + {4'h0, nib};
    end
    return ch;
  endfunction

  // Button synchronizer, idles high
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      send_meta_q <= 1'b1;
      send_sync_q <= 1'b1;
      send_prev_q <= 1'b1;
    end else begin
      send_meta_q <= send_ni;
      send_sync_q <= send_meta_q;
      send_prev_q <= send_sync_q;
    end
  end

  assign trigger = (send_prev_q && !send_sync_q) ||
                   (rx_byte_i.valid && rx_byte_i.data == DUMP_CMD);

  assign tx_valid_o = (state_q == ST_HEX) || (state_q == ST_LF);
  assign tx_data_o  = (state_q == ST_LF) ? ASCII_LF : hex_ascii(rd_rec_i.nibbles[nib_q]);
  assign tx_fire    = tx_valid_o && tx_ready_i;

  // Head record leaves the FIFO once its line feed is taken
  assign rd_en_o   = (state_q == ST_LF) && tx_ready_i;
  assign dumping_o = (state_q != ST_IDLE);

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= ST_IDLE;
      nib_q   <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (trigger) begin
            state_q <= ST_CHECK;
          end
        end
        ST_CHECK: begin
          nib_q <= 3'd7;
          if (empty_i) begin
            state_q <= ST_IDLE;
          end else begin
            state_q <= ST_HEX;
          end
        end
        ST_HEX: begin
          if (tx_fire) begin
            if (nib_q == 3'd0) begin
              state_q <= ST_LF;
            end else begin
              nib_q <= nib_q - 1'b1;
            end
          end
        end
        ST_LF: begin
          if (tx_fire) begin
            state_q <= ST_CHECK;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
  input  wire        clock,
  input  wire        arst_n,
  input  wire        valid_i,
  input  wire  [7:0] data_i,
  output logic       ready_o,
  output logic       tx_o
);
  import ddr3_tele_pkg::*;

  logic                              busy_q;
  logic [9:0]                        shift_q;
  logic [3:0]                        bit_q;
  logic [$clog2(CLKS_PER_BIT)-1:0]   clk_q;
  logic                              bit_end;

  assign bit_end = (clk_q == CLKS_PER_BIT - 1);
  assign ready_o = !busy_q;

  // Line sits on bit 0 of the frame, all ones when idle
  assign tx_o = shift_q[0];

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      busy_q  <= 1'b0;
      shift_q <= '1;
      bit_q   <= '0;
      clk_q   <= '0;
    end else if (!busy_q) begin
      if (valid_i) begin
        // Stop bit, data LSB first, start bit
        shift_q <= {1'b1, data_i, 1'b0};
        busy_q  <= 1'b1;
        bit_q   <= '0;
        clk_q   <= '0;
      end
    end else begin
      if (bit_end) begin
        clk_q   <= '0;
        shift_q <= {1'b1, shift_q[9:1]};
        bit_q   <= bit_q + 1'b1;
        if (bit_q == 4'd9) begin
          busy_q <= 1'b0;
        end
      end else begin
        clk_q <= clk_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
  input  wire                        clock,
  input  wire                        arst_n,
  input  wire                        rx_i,
  output ddr3_tele_pkg::uart_byte_t  byte_o
);
  import ddr3_tele_pkg::*;

  logic                              rx_meta_q;
  logic                              rx_sync_q;
  logic                              busy_q;
  logic                              valid_q;
  logic [3:0]                        bit_q;
  logic [$clog2(CLKS_PER_BIT)-1:0]   cnt_q;
  logic [7:0]                        data_q;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
    end else begin
      rx_meta_q <= rx_i;
      rx_sync_q <= rx_meta_q;
    end
  end

  always_ff @(posedge clock) begin
    // Data bits arrive LSB first
    if (busy_q && cnt_q == '0 && bit_q >= 4'd1 && bit_q <= 4'd8) begin
      data_q <= {rx_sync_q, data_q[7:1]};
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      busy_q  <= 1'b0;
      valid_q <= 1'b0;
      bit_q   <= '0;
      cnt_q   <= '0;
    end else begin
      valid_q <= 1'b0;
      if (!busy_q) begin
        if (!rx_sync_q) begin
          // Half a bit to reach the middle of the start bit
          busy_q <= 1'b1;
          bit_q  <= '0;
          cnt_q  <= ($clog2(CLKS_PER_BIT))'(CLKS_PER_BIT / 2 - 1);
        end
      end else if (cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
      end else begin
        cnt_q <= ($clog2(CLKS_PER_BIT))'(CLKS_PER_BIT - 1);
        bit_q <= bit_q + 1'b1;
        if (bit_q == 4'd0 && rx_sync_q) begin
          // Glitch, not a real start bit
          busy_q <= 1'b0;
        end else if (bit_q == 4'd9) begin
          busy_q  <= 1'b0;
          valid_q <= rx_sync_q;
        end
      end
    end
  end

  assign byte_o.valid = valid_q;
  assign byte_o.data  = data_q;

endmodule

`default_nettype wire

//--- ddr3_telemetry_top.sv
`timescale 1ns/1ps
`default_nettype none

module ddr3_telemetry_top (
  input  wire                                    clock,
  input  wire                                    arst_n,
  input  ddr3_tele_pkg::tele_snap_t              snap_i,
  input  wire                                    send_ni,
  input  wire                                    uart_rx_i,
  output logic                                   uart_tx_o,
  output logic                                   dumping_o,
  output logic [ddr3_tele_pkg::LEVEL_WIDTH-1:0]  tele_level_o
);
  import ddr3_tele_pkg::*;

  // Capture to FIFO
  logic       wr_en;
  tele_rec_t  wr_rec;
  logic       full;

  // FIFO to dump
  logic       rd_en;
  tele_rec_t  rd_rec;
  logic       empty;

  // Byte streams around the UART
  logic       tx_valid;
  logic       tx_ready;
  logic [7:0] tx_data;
  uart_byte_t rx_byte;

  tele_capture u_tele_capture (
    .clock     (clock),
    .arst_n    (arst_n),
    .snap_i    (snap_i),
    .dumping_i (dumping_o),
    .full_i    (full),
    .wr_en_o   (wr_en),
    .wr_rec_o  (wr_rec)
  );

  tele_fifo u_tele_fifo (
    .clock    (clock),
    .arst_n   (arst_n),
    .wr_en_i  (wr_en),
    .wr_rec_i (wr_rec),
    .rd_en_i  (rd_en),
    .rd_rec_o (rd_rec),
    .empty_o  (empty),
    .full_o   (full),
    .level_o  (tele_level_o)
  );

  tele_dump u_tele_dump (
    .clock      (clock),
    .arst_n     (arst_n),
    .send_ni    (send_ni),
    .rx_byte_i  (rx_byte),
    .rd_rec_i   (rd_rec),
    .empty_i    (empty),
    .tx_ready_i (tx_ready),
    .rd_en_o    (rd_en),
    .tx_valid_o (tx_valid),
    .tx_data_o  (tx_data),
    .dumping_o  (dumping_o)
  );

  uart_tx u_uart_tx (
    .clock   (clock),
    .arst_n  (arst_n),
    .valid_i (tx_valid),
    .data_i  (tx_data),
    .ready_o (tx_ready),
    .tx_o    (uart_tx_o)
  );

  uart_rx u_uart_rx (
    .clock  (clock),
    .arst_n (arst_n),
    .rx_i   (uart_rx_i),
    .byte_o (rx_byte)
  );

endmodule

`default_nettype wire

//--- ddr3_telemetry_checker.sv
`timescale 1ns/1ps
`default_nettype none

module ddr3_telemetry_checker (
  input wire                                   clock,
  input wire                                   arst_n,
  input wire                                   uart_tx_i,
  input wire                                   dumping_i,
  input wire [ddr3_tele_pkg::LEVEL_WIDTH-1:0]  tele_level_i
);
  import ddr3_tele_pkg::*;

  // Cycles with dumping_i low, saturates at one frame
  int unsigned idle_cnt;
  int unsigned fail_count = 0;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      idle_cnt <= 0;
    end else if (dumping_i) begin
      idle_cnt <= 0;
    end else if (idle_cnt < 10 * CLKS_PER_BIT) begin
      idle_cnt <= idle_cnt + 1;
    end
  end

  line_idle_a: assert property (@(posedge clock) disable iff (!arst_n)
    (idle_cnt >= 10 * CLKS_PER_BIT) |-> uart_tx_i)
  else begin
    $error("uart_tx_o low a full frame after the dump ended");
    fail_count++;
  end

  level_bound_a: assert property (@(posedge clock) disable iff (!arst_n)
    tele_level_i <= LEVEL_WIDTH'(TELE_DEPTH))
  else begin
    $error("tele_level_o above the FIFO depth");
    fail_count++;
  end

  // Writes only happen with the dump idle
  level_rise_a: assert property (@(posedge clock) disable iff (!arst_n)
    (tele_level_i > $past(tele_level_i)) |-> !$past(dumping_i))
  else begin
    $error("tele_level_o rose while dumping_o was high");
    fail_count++;
  end

  level_fall_a: assert property (@(posedge clock) disable iff (!arst_n)
    (tele_level_i < $past(tele_level_i)) |-> $past(dumping_i))
  else begin
    $error("tele_level_o fell outside a dump");
    fail_count++;
  end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clock,
  output logic arst_n
);

  // 10 ns period
  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // Reset held over the first five rising edges
  initial begin
    arst_n = 1'b0;
    repeat (5) @(posedge clock);
    #1;
    arst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- tb_ddr3_telemetry.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ddr3_telemetry;
  import ddr3_tele_pkg::*;

  typedef struct packed {
    tele_snap_t snap;
    logic [7:0] hold;
    logic       store;
  } stim_row_t;

  logic                   clock;
  logic                   arst_n;
  tele_snap_t             snap;
  logic                   send_n;
  logic                   uart_rx;
  logic                   uart_tx;
  logic                   dumping;
  logic [LEVEL_WIDTH-1:0] tele_level;

  stim_row_t              stim_q[$];
  logic [31:0]            exp_q[$];
  logic [7:0]             rx_q[$];
  logic [SEQ_WIDTH-1:0]   seq_cnt = '0;
  int                     error_count = 0;
  bit                     table_built = 1'b0;

  tb_clock_gen u_tb_clock_gen (
    .clock  (clock),
    .arst_n (arst_n)
  );

  ddr3_telemetry_top u_ddr3_telemetry_top (
    .clock        (clock),
    .arst_n       (arst_n),
    .snap_i       (snap),
    .send_ni      (send_n),
    .uart_rx_i    (uart_rx),
    .uart_tx_o    (uart_tx),
    .dumping_o    (dumping),
    .tele_level_o (tele_level)
  );

  bind ddr3_telemetry_top ddr3_telemetry_checker u_ddr3_telemetry_checker (
    .clock        (clock),
    .arst_n       (arst_n),
    .uart_tx_i    (uart_tx_o),
    .dumping_i    (dumping_o),
    .tele_level_i (tele_level_o)
  );

  task automatic stop_run();
    $display("Some tests failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic report_error(input string reason);
    error_count++;
    $display("%s at %0t ns", reason, $time);
    stop_run();
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("Fail at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
      stop_run();
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Upper-case ASCII digit for one nibble
  function automatic logic [7:0] hex_char(input logic [3:0] nib);
    if (nib <= 4'd9) begin
      return 8'd48 + 8'(nib);
    end
    return 8'd65 + 8'(nib) - 8'd10;
  endfunction

  // Every step ends 1 ns after a rising edge
  task automatic step_cycles(input int n);
    repeat (n) begin
      @(posedge clock);
      #1;
    end
  endtask

  task automatic add_row(input logic [19:0] value, input int hold, input logic store);
    stim_q.push_back('{snap: tele_snap_t'(value), hold: 8'(hold), store: store});
  endtask

  task automatic build_table();
    logic [31:0] rng;
    logic [19:0] value;
    logic [19:0] prev;
    logic        store;
    int          fill;
    int          i;
    rng = 32'd52329;
    // Zero, A, A again, B, back to A
    add_row(20'h00000, 3, 1'b0);
    add_row(20'hA5C31, 3, 1'b1);
    add_row(20'hA5C31, 3, 1'b0);
    add_row(20'h3F0E7, 3, 1'b1);
    add_row(20'hA5C31, 3, 1'b1);
    // Two records for the byte command dump
    add_row(20'h1B2D4, 2, 1'b1);
    add_row(20'hFFFFF, 2, 1'b1);
    // FIFO starts empty here and stops taking records at TELE_DEPTH
    prev = 20'hFFFFF;
    fill = 0;
    for (i = 0; i < 20; i++) begin
      rng = xorshift32(rng);
      value = rng[19:0];
      store = (value != prev) && (fill < TELE_DEPTH);
      add_row(value, 2, store);
      if (store) begin
        fill++;
      end
      prev = value;
    end
    // Stored, then changed during a dump, then stored after it
    add_row(20'h0C0DE, 2, 1'b1);
    add_row(20'h7E1A9, 2, 1'b1);
    add_row(20'h24680, 4, 1'b0);
    add_row(20'h13579, 4, 1'b0);
    add_row(20'hBEEF0, 2, 1'b1);
    add_row(20'h5A5A5, 2, 1'b1);
    table_built = 1'b1;
  endtask

  task automatic apply_rows(input int first, input int last);
    stim_row_t row;
    int        i;
    for (i = first; i <= last; i++) begin
      row = stim_q[i];
      snap = row.snap;
      if (row.store) begin
        exp_q.push_back({seq_cnt, row.snap});
        seq_cnt++;
      end
      step_cycles(row.hold);
    end
  endtask

  task automatic press_button();
    send_n = 1'b0;
    step_cycles(4);
    send_n = 1'b1;
  endtask

  // 8N1 frame on uart_rx_i, LSB first
  task automatic send_serial(input logic [7:0] data);
    int i;
    uart_rx = 1'b0;
    step_cycles(CLKS_PER_BIT);
    for (i = 0; i < 8; i++) begin
      uart_rx = data[i];
      step_cycles(CLKS_PER_BIT);
    end
    uart_rx = 1'b1;
    step_cycles(CLKS_PER_BIT);
  endtask

  task automatic wait_dumping(input logic level, input int limit);
    int n;
    n = 0;
    while (dumping !== level && n < limit) begin
      step_cycles(1);
      n++;
    end
    if (dumping !== level) begin
      report_error($sformatf("dumping_o did not go to %0b in time", level));
    end
  endtask

  task automatic expect_dump();
    logic [31:0] rec;
    int          n_rec;
    int          r;
    int          k;
    n_rec = exp_q.size();
    wait_dumping(1'b0, n_rec * 9 * 10 * CLKS_PER_BIT + 100);
    // Last line feed is still on the wire
    step_cycles(11 * CLKS_PER_BIT);
    check_value("decoded byte count", rx_q.size(), n_rec * 9);
    for (r = 0; r < n_rec; r++) begin
      rec = exp_q.pop_front();
      for (k = 7; k >= 0; k--) begin
        check_value("uart_tx_o hex byte", rx_q.pop_front(), hex_char(rec[4*k +: 4]));
      end
      check_value("uart_tx_o line feed", rx_q.pop_front(), 8'h0A);
    end
    check_value("tele_level_o", tele_level, 0);
    check_value("dumping_o", dumping, 0);
  endtask

  // Mid-bit sampling of uart_tx_o on falling edges
  initial begin : serial_decoder
    logic [7:0] data;
    int         i;
    forever begin
      @(negedge clock);
      if (arst_n === 1'b1 && uart_tx === 1'b0) begin
        repeat (CLKS_PER_BIT / 2 - 1) @(negedge clock);
        check_value("uart_tx_o start bit", uart_tx, 0);
        for (i = 0; i < 8; i++) begin
          repeat (CLKS_PER_BIT) @(negedge clock);
          data[i] = uart_tx;
        end
        repeat (CLKS_PER_BIT) @(negedge clock);
        check_value("uart_tx_o stop bit", uart_tx, 1);
        rx_q.push_back(data);
      end
    end
  end

  always @(negedge clock) begin
    if (u_ddr3_telemetry_top.u_ddr3_telemetry_checker.fail_count != 0) begin
      report_error("An assertion in the bound checker failed");
    end
  end

  initial begin : watchdog
    int limit;
    int i;
    wait (table_built);
    limit = 30 * 10 * CLKS_PER_BIT;
    for (i = 0; i < stim_q.size(); i++) begin
      limit += stim_q[i].hold;
      if (stim_q[i].store) begin
        limit += 9 * 10 * CLKS_PER_BIT;
      end
    end
    repeat (limit) @(posedge clock);
    report_error("Watchdog timeout, the tests did not finish in time");
  end

  initial begin : main_sequence
    int i;
    int high_cycles;
    snap = '0;
    send_n = 1'b1;
    uart_rx = 1'b1;
    build_table();
    @(posedge arst_n);
    check_value("tele_level_o", tele_level, 0);
    check_value("dumping_o", dumping, 0);
    check_value("uart_tx_o", uart_tx, 1);

    apply_rows(0, 4);
    check_value("tele_level_o", tele_level, 3);
    press_button();
    wait_dumping(1'b1, 8);
    expect_dump();

    // Only the command byte starts a dump
    apply_rows(5, 6);
    check_value("tele_level_o", tele_level, 2);
    send_serial("b");
    for (i = 0; i < 2 * CLKS_PER_BIT; i++) begin
      check_value("dumping_o", dumping, 0);
      step_cycles(1);
    end
    check_value("tele_level_o", tele_level, 2);
    send_serial("a");
    wait_dumping(1'b1, 4 * CLKS_PER_BIT);
    expect_dump();

    apply_rows(7, 26);
    check_value("tele_level_o", tele_level, TELE_DEPTH);
    press_button();
    wait_dumping(1'b1, 8);
    expect_dump();

    apply_rows(27, 28);
    press_button();
    wait_dumping(1'b1, 8);
    apply_rows(29, 30);
    check_value("dumping_o", dumping, 1);
    expect_dump();
    apply_rows(31, 32);
    check_value("tele_level_o", tele_level, 2);
    press_button();
    wait_dumping(1'b1, 8);
    expect_dump();

    // Empty FIFO gives a single dumping cycle and a quiet line
    high_cycles = 0;
    send_n = 1'b0;
    for (i = 0; i < 12; i++) begin
      if (i == 4) begin
        send_n = 1'b1;
      end
      step_cycles(1);
      if (dumping === 1'b1) begin
        high_cycles++;
      end
    end
    check_value("dumping_o high cycles", high_cycles, 1);
    for (i = 0; i < 10 * CLKS_PER_BIT; i++) begin
      check_value("uart_tx_o", uart_tx, 1);
      step_cycles(1);
    end
    check_value("decoded byte count", rx_q.size(), 0);

    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
ddr3_tele_pkg.sv
tele_fifo.sv
tele_capture.sv
tele_dump.sv
uart_tx.sv
uart_rx.sv
ddr3_telemetry_top.sv
ddr3_telemetry_checker.sv
tb_clock_gen.sv
tb_ddr3_telemetry.sv

//--- Bender.yml
package:
  name: ddr3_telemetry

sources:
  - ddr3_tele_pkg.sv
  - tele_fifo.sv
  - tele_capture.sv
  - tele_dump.sv
  - uart_tx.sv
  - uart_rx.sv
  - ddr3_telemetry_top.sv
  - target: test
    files:
      - ddr3_telemetry_checker.sv
      - tb_clock_gen.sv
      - tb_ddr3_telemetry.sv
